// File: design/video_pkg.sv
//////////////////////////////
// video timing package
// coordinate type and test-mode display timing
//////////////////////////////
package video_pkg;

    // signed so blanking can sit left of or above the origin
    typedef logic signed [15:0] coord_t;

    // horizontal timing in pixel clocks, 40 per line
    parameter int H_RES  = 32;  // visible pixels
    parameter int H_FP   = 2;   // front porch
    parameter int H_SYNC = 4;   // sync pulse
    parameter int H_BP   = 2;   // back porch

    // vertical timing in lines, 28 per frame
    parameter int V_RES  = 24;  // visible lines
    parameter int V_FP   = 1;
    parameter int V_SYNC = 2;
    parameter int V_BP   = 1;

    // sync polarity
    parameter logic SYNC_ACT = 1'b0;  // hsync and vsync active low

    // display_timing output to pins
    // bank read, index reg, colour reg
    parameter int PIPE_LAT = 3;

endpackage

// File: design/fb_pkg.sv
//////////////////////////////
// framebuffer package
// geometry, colour types, palette and LFSR constants
//////////////////////////////
package fb_pkg;

    // framebuffer geometry, shown top left
    parameter int FB_WIDTH  = 16;
    parameter int FB_HEIGHT = 12;
    parameter int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 192

    typedef logic [7:0]  fb_addr_t;  // linear pixel address
    typedef logic [3:0]  cidx_t;     // colour index into palette
    typedef logic [11:0] colr_t;     // {red, green, blue}, 4 bits each

    // 16-entry colour lookup table
    // entry 0 is not black so painted pixels differ from the border
    parameter colr_t PALETTE [16] = '{
        12'h112,  // 0 navy
        12'h235,  // 1 dark blue
        12'h725,  // 2 plum
        12'h085,  // 3 dark green
        12'hA53,  // 4 brown
        12'h655,  // 5 grey brown
        12'hCCC,  // 6 light grey
        12'hFFE,  // 7 off white
        12'hF05,  // 8 red
        12'hFA0,  // 9 orange
        12'hFE3,  // 10 yellow
        12'h0E3,  // 11 green
        12'h2AF,  // 12 sky blue
        12'h879,  // 13 lavender
        12'hF7A,  // 14 pink
        12'hFCA   // 15 peach, fade colour
    };

    parameter cidx_t FADE_CIDX = 4'd15;  // painted by the fade

    // x^8 + x^6 + x^5 + x^4 + 1, maximal length 255
    parameter fb_addr_t LFSR_TAPS = 8'b1011_1000;
    parameter fb_addr_t LFSR_SEED = 8'd1;  // any non-zero value works

endpackage

// File: design/fb_bank_if.sv
//////////////////////////////
// framebuffer bank interface
// write port and read port of one bank
//////////////////////////////
`timescale 1ns/10ps

interface fb_bank_if #(
    parameter int LAW = 6  // bank-local address width
);
    logic              we;     // write strobe
    logic [LAW-1:0]    waddr;  // bank-local write address
    fb_pkg::cidx_t     wdata;
    logic [LAW-1:0]    raddr;  // bank-local read address
    fb_pkg::cidx_t     rdata;  // valid one cycle after raddr

    modport router (output we, waddr, wdata);
    modport reader (output raddr, input rdata);
    modport bank   (input we, waddr, wdata, raddr, output rdata);
endinterface

// File: design/display_timing.sv
//////////////////////////////
// display timing generator
// coordinates, syncs, data enable and frame pulse
//////////////////////////////
`timescale 1ns/10ps

module display_timing #(
    parameter int H_RES  = video_pkg::H_RES,
    parameter int H_FP   = video_pkg::H_FP,
    parameter int H_SYNC = video_pkg::H_SYNC,
    parameter int H_BP   = video_pkg::H_BP,
    parameter int V_RES  = video_pkg::V_RES,
    parameter int V_FP   = video_pkg::V_FP,
    parameter int V_SYNC = video_pkg::V_SYNC,
    parameter int V_BP   = video_pkg::V_BP
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    output video_pkg::coord_t  sx,     // column, 0 is first visible
    output video_pkg::coord_t  sy,     // line, 0 is first visible
    output logic               hsync,
    output logic               vsync,
    output logic               de,     // visible area
    output logic               frame   // last cycle of the frame
);
    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;
    localparam int HS_STA  = H_RES + H_FP;  // first sync column
    localparam int HS_END  = HS_STA + H_SYNC;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;

    localparam video_pkg::coord_t H_LAST = video_pkg::coord_t'(H_TOTAL - 1);
    localparam video_pkg::coord_t V_LAST = video_pkg::coord_t'(V_TOTAL - 1);
    localparam video_pkg::coord_t ONE    = video_pkg::coord_t'(1);

    video_pkg::coord_t sx_nxt, sy_nxt;
    logic              line_end;

    // next position, outputs are decoded from it so all stay aligned
    always_comb begin
        line_end = (sx == H_LAST);
        sx_nxt   = line_end ? '0 : sx + ONE;
        sy_nxt   = sy;
        if (line_end) begin
            sy_nxt = (sy == V_LAST) ? '0 : sy + ONE;  // wrap at frame end
        end
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            sx    <= H_LAST;  // park on last cycle, (0,0) comes next
            sy    <= V_LAST;
            hsync <= ~video_pkg::SYNC_ACT;
            vsync <= ~video_pkg::SYNC_ACT;
            de    <= 1'b0;
            frame <= 1'b0;
        end else begin
            sx    <= sx_nxt;
            sy    <= sy_nxt;
            hsync <= (sx_nxt >= HS_STA && sx_nxt < HS_END) ?
                     video_pkg::SYNC_ACT : ~video_pkg::SYNC_ACT;
            vsync <= (sy_nxt >= VS_STA && sy_nxt < VS_END) ?
                     video_pkg::SYNC_ACT : ~video_pkg::SYNC_ACT;
            de    <= (sx_nxt < H_RES) && (sy_nxt < V_RES);  // counters never negative
            frame <= (sx_nxt == H_LAST) && (sy_nxt == V_LAST);
        end
    end

    // every hsync pulse is exactly H_SYNC clocks wide
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        $fell(hsync) |-> (!hsync) [*H_SYNC] ##1 hsync)
        else $error("hsync low pulse differs from %0d cycles", H_SYNC);

endmodule

// File: design/fade_ctrl.sv
//////////////////////////////
// fizzlefade controller
// paints LFSR-chosen pixels after a frame delay
//////////////////////////////
`timescale 1ns/10ps

module fade_ctrl #(
    parameter int FADE_WAIT = 600,   // frames before fading starts
    parameter int FADE_RATE = 3200   // cycles between fade writes
) (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              frame,      // end of frame pulse
    input  logic              fade_en,
    output logic              fade_we,    // one-cycle write strobe
    output fb_pkg::fb_addr_t  fade_addr,
    output fb_pkg::cidx_t     fade_cidx,
    output logic              fade_done
);
    localparam int WAIT_W = (FADE_WAIT > 1) ? $clog2(FADE_WAIT) : 1;
    localparam int RATE_W = (FADE_RATE > 1) ? $clog2(FADE_RATE) : 1;
    localparam int LW     = $bits(fb_pkg::fb_addr_t);

    typedef enum logic [1:0] {IDLE, WAITING, FADING, DONE} state_t;

    state_t            state;
    logic [WAIT_W-1:0] cnt_wait;  // frames seen
    logic [RATE_W-1:0] cnt_rate;  // cycles since last write
    fb_pkg::fb_addr_t  lfsr, lfsr_nxt;
    logic              tick;

    // fibonacci step, shift left with xor feedback
    always_comb begin
        lfsr_nxt = {lfsr[LW-2:0], ^(lfsr & fb_pkg::LFSR_TAPS)};
        tick     = (state == FADING) && (cnt_rate == RATE_W'(FADE_RATE - 1));
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n || !fade_en) begin  // dropping fade_en restarts from scratch
            state    <= IDLE;
            cnt_wait <= '0;
            cnt_rate <= '0;
            lfsr     <= fb_pkg::LFSR_SEED;
            fade_we  <= 1'b0;
        end else begin
            fade_we <= tick;
            case (state)
                IDLE:    state <= WAITING;
                WAITING: if (frame) begin
                    cnt_wait <= cnt_wait + 1'b1;
                    if (cnt_wait == WAIT_W'(FADE_WAIT - 1)) state <= FADING;
                end
                FADING: begin
                    cnt_rate <= tick ? '0 : cnt_rate + 1'b1;
                    if (tick) begin
                        lfsr <= lfsr_nxt;
                        // back at the seed, all 255 values written
                        if (lfsr_nxt == fb_pkg::LFSR_SEED) state <= DONE;
                    end
                end
                default: state <= DONE;  // hold until fade_en drops
            endcase
        end
    end

    // write payload, current LFSR value before the step
    always_ff @(posedge clk_pix) begin
        if (tick) begin
            fade_addr <= lfsr;
            fade_cidx <= fb_pkg::FADE_CIDX;
        end
    end

    assign fade_done = (state == DONE);

endmodule

// File: design/fb_write_router.sv
//////////////////////////////
// framebuffer write router
// host/fade arbitration and bank steering
//////////////////////////////
`timescale 1ns/10ps

module fb_write_router #(
    parameter int N_BANKS = 4
) (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              wr_en,      // host, always wins
    input  fb_pkg::fb_addr_t  wr_addr,
    input  fb_pkg::cidx_t     wr_cidx,
    input  logic              fade_we,
    input  fb_pkg::fb_addr_t  fade_addr,
    input  fb_pkg::cidx_t     fade_cidx,
    fb_bank_if.router         banks [N_BANKS]
);
    localparam int BANK_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
    localparam int LAW    = $bits(fb_pkg::fb_addr_t) - $clog2(N_BANKS);

    logic              pend_v;  // fade write held back by the host
    fb_pkg::fb_addr_t  pend_addr;
    fb_pkg::cidx_t     pend_cidx;
    logic              w_en, w_ok;
    fb_pkg::fb_addr_t  w_addr;
    fb_pkg::cidx_t     w_cidx;
    logic [BANK_W-1:0] w_bank;
    logic [LAW-1:0]    w_local;

    // priority host, then pending fade, then new fade
    always_comb begin
        w_en   = fade_we;
        w_addr = fade_addr;
        w_cidx = fade_cidx;
        if (pend_v) begin
            w_en   = 1'b1;
            w_addr = pend_addr;
            w_cidx = pend_cidx;
        end
        if (wr_en) begin
            w_en   = 1'b1;
            w_addr = wr_addr;
            w_cidx = wr_cidx;
        end
        w_ok    = w_en && (w_addr < fb_pkg::FB_PIXELS);  // drop off-screen
        w_bank  = BANK_W'(w_addr % N_BANKS);             // interleave on low bits
        w_local = LAW'(w_addr / N_BANKS);
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) pend_v <= 1'b0;
        else if (wr_en) pend_v <= pend_v | fade_we;  // host busy, keep or take
        else pend_v <= pend_v & fade_we;             // drained, refill if new strobe
    end

    always_ff @(posedge clk_pix) begin
        if (fade_we && (wr_en || pend_v)) begin
            pend_addr <= fade_addr;
            pend_cidx <= fade_cidx;
        end
    end

    for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
        assign banks[g].we    = w_ok && (w_bank == BANK_W'(g));
        assign banks[g].waddr = w_local;  // shared, only one bank strobed
        assign banks[g].wdata = w_cidx;
    end

endmodule

// File: design/fb_bank.sv
//////////////////////////////
// framebuffer bank
// simple dual-port RAM, registered read
//////////////////////////////
`timescale 1ns/10ps

module fb_bank #(
    parameter int DEPTH = 48  // indexes held by this bank
) (
    input  logic       clk_pix,
    fb_bank_if.bank    port
);
    fb_pkg::cidx_t mem [DEPTH];  // contents undefined until written

    // read sees old data when both ports hit one address
    always_ff @(posedge clk_pix) begin
        if (port.we) begin
            mem[port.waddr] <= port.wdata;
        end
        port.rdata <= mem[port.raddr];  // one cycle read latency
    end

endmodule

// File: design/pixel_pipe.sv
//////////////////////////////
// pixel pipeline
// bank read, palette lookup, sync alignment
//////////////////////////////
`timescale 1ns/10ps

module pixel_pipe #(
    parameter int N_BANKS = 4
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  video_pkg::coord_t  sx,
    input  video_pkg::coord_t  sy,
    input  logic               hsync,
    input  logic               vsync,
    input  logic               de,
    input  logic               frame,
    fb_bank_if.reader          banks [N_BANKS],
    output logic               hsync_o,
    output logic               vsync_o,
    output logic               de_o,
    output logic [3:0]         red,
    output logic [3:0]         green,
    output logic [3:0]         blue
);
    localparam int BANK_W = (N_BANKS > 1) ? $clog2(N_BANKS) : 1;
    localparam int LAW    = $bits(fb_pkg::fb_addr_t) - $clog2(N_BANKS);
    localparam int LAT    = video_pkg::PIPE_LAT;

    logic              paint;          // inside framebuffer area
    fb_pkg::fb_addr_t  rd_addr;        // linear read address
    logic [BANK_W-1:0] rd_bank, bank_d1;
    logic [LAW-1:0]    rd_local;
    fb_pkg::cidx_t     rdata_all [N_BANKS];
    fb_pkg::cidx_t     rd_sel, cidx_q;
    fb_pkg::colr_t     colr;
    logic              paint_d1, paint_d2;
    logic [LAT-1:0]    hs_sr, vs_sr, de_sr;  // sync delay lines

    always_comb begin
        paint    = (sx >= 0) && (sx < fb_pkg::FB_WIDTH) &&
                   (sy >= 0) && (sy < fb_pkg::FB_HEIGHT);
        rd_bank  = BANK_W'(rd_addr % N_BANKS);
        rd_local = LAW'(rd_addr / N_BANKS);
        rd_sel   = rdata_all[bank_d1];          // bank picked a cycle late
        colr     = fb_pkg::PALETTE[cidx_q];     // async CLUT
    end

    // address follows the raster through the painted area
    always_ff @(posedge clk_pix) begin
        if (!rst_n || frame) rd_addr <= '0;  // restart for the next frame
        else if (paint) rd_addr <= rd_addr + 1'b1;
    end

    for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
        assign banks[g].raddr = rd_local;  // all banks read in step
        assign rdata_all[g]   = banks[g].rdata;
    end

    always_ff @(posedge clk_pix) begin
        bank_d1 <= rd_bank;  // lines up with rdata
        cidx_q  <= rd_sel;   // breaks RAM to CLUT path
    end

    always_ff @(posedge clk_pix) begin
        if (!rst_n) begin
            paint_d1 <= 1'b0;
            paint_d2 <= 1'b0;
            hs_sr    <= {LAT{~video_pkg::SYNC_ACT}};
            vs_sr    <= {LAT{~video_pkg::SYNC_ACT}};
            de_sr    <= '0;
            {red, green, blue} <= '0;
        end else begin
            paint_d1 <= paint;
            paint_d2 <= paint_d1;
            hs_sr    <= {hs_sr[LAT-2:0], hsync};
            vs_sr    <= {vs_sr[LAT-2:0], vsync};
            de_sr    <= {de_sr[LAT-2:0], de};
            {red, green, blue} <= paint_d2 ? colr : '0;  // black border
        end
    end

    assign hsync_o = hs_sr[LAT-1];
    assign vsync_o = vs_sr[LAT-1];
    assign de_o    = de_sr[LAT-1];

    // painted pixels must come from loaded memory
    assert property (@(posedge clk_pix) disable iff (!rst_n)
        paint_d1 |-> !$isunknown(rd_sel))
        else $error("unknown framebuffer data in painted area");

endmodule

// File: design/fb_display_top.sv
//////////////////////////////
// framebuffer display top level
// timing, fade, write router, banks and pixel pipe
//////////////////////////////
`timescale 1ns/10ps

module fb_display_top #(
    parameter int N_BANKS   = 4,     // power of two
    parameter int FADE_WAIT = 600,   // frames
    parameter int FADE_RATE = 3200   // cycles
) (
    input  logic              clk_pix,
    input  logic              rst_n,
    input  logic              wr_en,     // host write strobe
    input  fb_pkg::fb_addr_t  wr_addr,
    input  fb_pkg::cidx_t     wr_cidx,
    input  logic              fade_en,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic [3:0]        red,
    output logic [3:0]        green,
    output logic [3:0]        blue,
    output logic              fade_done
);
    localparam int LAW   = $bits(fb_pkg::fb_addr_t) - $clog2(N_BANKS);
    localparam int DEPTH = fb_pkg::FB_PIXELS / N_BANKS;  // per bank

    video_pkg::coord_t sx, sy;
    logic              t_hsync, t_vsync, t_de, frame;  // raw timing
    logic              fade_we;
    fb_pkg::fb_addr_t  fade_addr;
    fb_pkg::cidx_t     fade_cidx;

    fb_bank_if #(.LAW(LAW)) bank_bus [N_BANKS] ();

    display_timing #(
        .H_RES(video_pkg::H_RES), .H_FP(video_pkg::H_FP),
        .H_SYNC(video_pkg::H_SYNC), .H_BP(video_pkg::H_BP),
        .V_RES(video_pkg::V_RES), .V_FP(video_pkg::V_FP),
        .V_SYNC(video_pkg::V_SYNC), .V_BP(video_pkg::V_BP)
    ) display_timing_i (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(t_hsync), .vsync(t_vsync), .de(t_de), .frame
    );

    fade_ctrl #(.FADE_WAIT(FADE_WAIT), .FADE_RATE(FADE_RATE)) fade_ctrl_i (
        .clk_pix, .rst_n, .frame, .fade_en,
        .fade_we, .fade_addr, .fade_cidx, .fade_done
    );

    fb_write_router #(.N_BANKS(N_BANKS)) fb_write_router_i (
        .clk_pix, .rst_n, .wr_en, .wr_addr, .wr_cidx,
        .fade_we, .fade_addr, .fade_cidx, .banks(bank_bus)
    );

    for (genvar g = 0; g < N_BANKS; g++) begin : g_bank
        fb_bank #(.DEPTH(DEPTH)) fb_bank_i (.clk_pix, .port(bank_bus[g]));
    end

    pixel_pipe #(.N_BANKS(N_BANKS)) pixel_pipe_i (
        .clk_pix, .rst_n, .sx, .sy,
        .hsync(t_hsync), .vsync(t_vsync), .de(t_de), .frame,
        .banks(bank_bus),
        .hsync_o(hsync), .vsync_o(vsync), .de_o(de),
        .red, .green, .blue
    );

endmodule

// File: test/tb_fb_display.sv
//////////////////////////////
// framebuffer display testbench
// directed tests against a reference framebuffer
//////////////////////////////
`timescale 1ns/10ps

module tb_fb_display;
    localparam int N_BANKS = 4;
    localparam int H_TOTAL = video_pkg::H_RES + video_pkg::H_FP +
                             video_pkg::H_SYNC + video_pkg::H_BP;  // 40
    localparam int V_TOTAL = video_pkg::V_RES + video_pkg::V_FP +
                             video_pkg::V_SYNC + video_pkg::V_BP;  // 28
    localparam int FRAME_CYC  = H_TOTAL * V_TOTAL;                  // 1120
    localparam int VIS_PIX    = video_pkg::H_RES * video_pkg::V_RES;
    localparam int RUN_FRAMES = 16;  // the two fade runs take about four each
    localparam int MARGIN_FR  = 4;

    logic             clk_pix, rst_n;
    logic             wr_en, fade_en;
    fb_pkg::fb_addr_t wr_addr;
    fb_pkg::cidx_t    wr_cidx;
    logic             hsync, vsync, de, fade_done;
    logic [3:0]       red, green, blue;

    fb_pkg::cidx_t    model [fb_pkg::FB_PIXELS];  // reference framebuffer
    fb_pkg::colr_t    shot [VIS_PIX];              // one captured frame, raster order
    logic [15:0]      lfsr_state;
    logic [4:0]       rst_seen;                    // outputs as reset ends
    string            cur_test;
    int               test_errs, run_tests, fail_tests, total_errs;

    fb_display_top #(.N_BANKS(N_BANKS), .FADE_WAIT(2), .FADE_RATE(8)) fb_display_top_i (
        .clk_pix, .rst_n, .wr_en, .wr_addr, .wr_cidx, .fade_en,
        .hsync, .vsync, .de, .red, .green, .blue, .fade_done
    );

    initial begin
        clk_pix = 1'b0;
        forever #5 clk_pix = ~clk_pix;  // 100 MHz pixel clock
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);  // one step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("mismatch %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_true(input bit ok, input string msg);
        assert (ok) else begin
            $display("%s: %s", cur_test, msg);
            test_errs++;
        end
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        run_tests++;
        total_errs += test_errs;
        if (test_errs != 0) fail_tests++;
        $display("test %s: %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "failed",
                 test_errs);
    endtask

    // one write per call, wr_en left high for back-to-back writes
    task automatic host_write(input int addr, input int cidx);
        @(negedge clk_pix);
        wr_en   = 1'b1;
        wr_addr = fb_pkg::fb_addr_t'(addr);
        wr_cidx = fb_pkg::cidx_t'(cidx);
        if (addr < fb_pkg::FB_PIXELS) model[addr] = fb_pkg::cidx_t'(cidx);  // off-screen dropped
    endtask

    task automatic host_release();
        @(negedge clk_pix);
        wr_en = 1'b0;
    endtask

    task automatic apply_reset();
        repeat (3) @(posedge clk_pix);
        @(negedge clk_pix);
        rst_seen = {hsync, vsync, de, |{red, green, blue}, fade_done};
        rst_n    = 1'b1;
    endtask

    task automatic wait_vsync_fall();
        logic prev;
        prev = vsync;
        forever begin
            @(negedge clk_pix);
            if (prev === 1'b1 && vsync === 1'b0) break;
            prev = vsync;
        end
    endtask

    // next whole frame, the k-th de cycle is pixel k
    task automatic capture_frame();
        int k;
        wait_vsync_fall();
        while (vsync !== 1'b1) @(negedge clk_pix);
        k = 0;
        while (k < VIS_PIX) begin
            @(negedge clk_pix);
            if (de === 1'b1) begin
                shot[k] = {red, green, blue};
                k++;
            end
        end
    endtask

    task automatic compare_frame();
        fb_pkg::colr_t exp;
        int x, y;
        for (int k = 0; k < VIS_PIX; k++) begin
            x   = k % video_pkg::H_RES;
            y   = k / video_pkg::H_RES;
            exp = '0;  // black outside the framebuffer
            if (x < fb_pkg::FB_WIDTH && y < fb_pkg::FB_HEIGHT) begin
                exp = fb_pkg::PALETTE[model[y * fb_pkg::FB_WIDTH + x]];
            end
            check_val($sformatf("pixel x%0d y%0d", x, y), exp, shot[k]);
        end
    endtask

    task automatic wait_fade_done();
        int n;
        n = 0;
        while (fade_done !== 1'b1 && n < 5 * FRAME_CYC) begin
            @(negedge clk_pix);
            n++;
        end
        check_true(fade_done === 1'b1, "fade_done did not rise within five frames");
    endtask

    // in order from address 0, stays ahead of the raster read
    task automatic test_full_load();
        begin_test("full_load");
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) begin
            host_write(a, a % 16);
        end
        host_release();
        capture_frame();
        compare_frame();
        end_test();
    endtask

    task automatic test_timing();
        int   vs_run, hs_run, last_fall, lines, de_cnt, hs_falls;
        logic hs_prev;
        begin_test("timing");
        check_val("syncs, de, colour, fade_done after reset", 5'b11000, rst_seen);
        wait_vsync_fall();
        vs_run    = 0;
        hs_run    = 0;
        last_fall = -1;
        lines     = 0;
        de_cnt    = 0;
        hs_falls  = 0;
        hs_prev   = hsync;
        for (int i = 0; i < FRAME_CYC; i++) begin  // one frame from vsync fall
            if (vsync === 1'b0) vs_run++;
            if (hs_prev === 1'b1 && hsync === 1'b0) begin  // line boundary
                if (last_fall >= 0) check_val("line period", H_TOTAL, i - last_fall);
                if (de_cnt > 0) begin
                    lines++;
                    check_val("de cycles in a line", video_pkg::H_RES, de_cnt);
                end
                last_fall = i;
                de_cnt    = 0;
                hs_falls++;
            end
            if (hsync === 1'b0) hs_run++;
            if (hs_prev === 1'b0 && hsync === 1'b1) begin
                check_val("hsync low width", video_pkg::H_SYNC, hs_run);
                hs_run = 0;
            end
            if (de === 1'b1) de_cnt++;
            hs_prev = hsync;
            @(negedge clk_pix);
        end
        check_val("vsync low width", video_pkg::V_SYNC * H_TOTAL, vs_run);
        check_val("visible lines", video_pkg::V_RES, lines);
        check_val("lines per frame", V_TOTAL, hs_falls);
        end_test();
    endtask

    task automatic test_bank_spread();
        logic [N_BANKS-1:0] hit;
        int                 a;
        begin_test("bank_spread");
        hit = '0;
        for (int i = 0; i < 40; i++) begin
            a = rand_bits(8) % fb_pkg::FB_PIXELS;
            hit[a % N_BANKS] = 1'b1;  // low bits pick the bank
            host_write(a, rand_bits(4));
        end
        host_release();
        check_true(&hit, "random writes did not reach every bank");
        capture_frame();
        compare_frame();
        end_test();
    endtask

    task automatic test_range_drop();
        begin_test("range_drop");
        host_write(200, 9);  // past the last pixel
        host_release();
        capture_frame();
        compare_frame();
        end_test();
    endtask

    task automatic test_fizzlefade();
        begin_test("fizzlefade");
        @(negedge clk_pix);
        fade_en = 1'b1;
        wait_fade_done();
        for (int a = 1; a < fb_pkg::FB_PIXELS; a++) begin
            model[a] = fb_pkg::FADE_CIDX;  // LFSR never hits 0
        end
        capture_frame();
        compare_frame();
        end_test();
    endtask

    // host hammers one pixel for the whole fade
    task automatic test_collision();
        begin_test("collision");
        @(negedge clk_pix);
        fade_en = 1'b0;  // idle and reseed
        host_write(77, 6);
        fade_en = 1'b1;
        wait_fade_done();
        host_release();
        capture_frame();
        compare_frame();
        end_test();
    endtask

    initial begin
        rst_n      = 1'b0;
        wr_en      = 1'b0;
        wr_addr    = '0;
        wr_cidx    = '0;
        fade_en    = 1'b0;
        lfsr_state = 16'd29;
        run_tests  = 0;
        fail_tests = 0;
        total_errs = 0;
        fork
            apply_reset();
            test_full_load();  // loading starts inside reset
        join
        test_timing();
        test_bank_spread();
        test_range_drop();
        test_fizzlefade();
        test_collision();
        $display("%0d tests run, %0d failed, %0d check errors", run_tests, fail_tests,
                 total_errs);
        if (fail_tests == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RUN_FRAMES + MARGIN_FR) * FRAME_CYC * 10);
        $display("timeout: tests still running after %0d frames", RUN_FRAMES + MARGIN_FR);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: build.f
design/video_pkg.sv
design/fb_pkg.sv
design/fb_bank_if.sv
design/display_timing.sv
design/fade_ctrl.sv
design/fb_write_router.sv
design/fb_bank.sv
design/pixel_pipe.sv
design/fb_display_top.sv
test/tb_fb_display.sv

// File: Bender.yml
package:
  name: fb_display

sources:
  - design/video_pkg.sv
  - design/fb_pkg.sv
  - design/fb_bank_if.sv
  - design/display_timing.sv
  - design/fade_ctrl.sv
  - design/fb_write_router.sv
  - design/fb_bank.sv
  - design/pixel_pipe.sv
  - design/fb_display_top.sv
  - target: test
    files:
      - test/tb_fb_display.sv
